//--- flist.f
+incdir+common
common/switch_pkg.sv
common/switch_if.sv
switch/switch_config.sv
switch/output_port.sv
switch/credit_merge.sv
verilog/dyser_switch.sv
tests/switch_checker.sv
tests/tb_dyser_switch.sv

//--- Makefile
# Verilator flow for the routing switch

VERILATOR ?= verilator
FLIST     ?= flist.f
RTL_TOP   ?= dyser_switch
TB_TOP    ?= tb_dyser_switch
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= all tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# The run passes only when the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_dyser_switch.sv
// Testbench top for the routing switch
// Clock, reset, random configurations and credit limited link models

`timescale 1ns/10ps
`include "dyser_switch_settings.svh"

module tb_dyser_switch;

    localparam int NUM_IN  = `SW_NUM_IN;
    localparam int NUM_OUT = `SW_NUM_OUT;
    localparam int DW      = `SW_DATA_WIDTH;
    localparam int CW      = `SW_CONF_WIDTH;
    localparam int CHUNK   = `SW_CONF_CHUNK;
    localparam int SW      = `SW_SEL_WIDTH;
    localparam int DEPTH   = `SW_QUEUE_DEPTH;

    logic                         clk;
    logic                         rst;
    logic                         conf_en;
    logic [NUM_IN-1:0][DW-1:0]    in_data;
    logic [NUM_IN-1:0]            in_valid;
    logic [NUM_IN-1:0]            in_credit;
    logic [NUM_OUT-1:0][DW-1:0]   out_data;
    logic [NUM_OUT-1:0]           out_valid;
    logic [NUM_OUT-1:0]           out_credit;

    integer            seed;
    int                up_credit [NUM_IN];
    int                owed [NUM_OUT];
    logic [NUM_IN-1:0] used;
    logic              hold_credit;
    int                r;

    dyser_switch u_dut (
        .clk          (clk),
        .rst          (rst),
        .conf_en      (conf_en),
        .in_nw_data   (in_data[0]),
        .in_n_data    (in_data[1]),
        .in_e_data    (in_data[2]),
        .in_s_data    (in_data[3]),
        .in_w_data    (in_data[4]),
        .in_nw_valid  (in_valid[0]),
        .in_n_valid   (in_valid[1]),
        .in_e_valid   (in_valid[2]),
        .in_s_valid   (in_valid[3]),
        .in_w_valid   (in_valid[4]),
        .in_nw_credit (in_credit[0]),
        .in_n_credit  (in_credit[1]),
        .in_e_credit  (in_credit[2]),
        .in_s_credit  (in_credit[3]),
        .in_w_credit  (in_credit[4]),
        .out_n_data   (out_data[0]),
        .out_e_data   (out_data[1]),
        .out_s_data   (out_data[2]),
        .out_w_data   (out_data[3]),
        .out_n_valid  (out_valid[0]),
        .out_e_valid  (out_valid[1]),
        .out_s_valid  (out_valid[2]),
        .out_w_valid  (out_valid[3]),
        .out_n_credit (out_credit[0]),
        .out_e_credit (out_credit[1]),
        .out_s_credit (out_credit[2]),
        .out_w_credit (out_credit[3])
    );

    switch_checker u_chk (
        .clk        (clk),
        .rst        (rst),
        .conf_en    (conf_en),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_credit  (in_credit),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic bit coin();
        return ($random(seed) & 1) == 1;
    endfunction

    function automatic int rand_below(input int n);
        return int'(($random(seed) & 32'h7fffffff) % n);
    endfunction

    // Field 0 is output n in the low bits
    function automatic logic [CW-1:0] pack_conf(input int f0, input int f1,
                                                input int f2, input int f3);
        return {SW'(f3), SW'(f2), SW'(f1), SW'(f0)};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Link models stepped one clock per call
    //////////////////////////////////////////////////////////////////////

    // Sample pulses mid cycle and drive just after the rising edge
    task automatic step(input bit send);
        @(negedge clk);
        for (int i = 0; i < NUM_IN; i++) begin
            if (in_credit[i]) up_credit[i]++;
        end
        for (int o = 0; o < NUM_OUT; o++) begin
            if (out_valid[o]) owed[o]++;
        end
        @(posedge clk);
        #1;
        for (int o = 0; o < NUM_OUT; o++) begin
            out_credit[o] = 1'b0;
            if (!hold_credit && owed[o] > 0 && coin()) begin
                out_credit[o] = 1'b1;
                owed[o]--;
            end
        end
        for (int i = 0; i < NUM_IN; i++) begin
            in_valid[i] = 1'b0;
            in_data[i]  = DW'($random(seed));
            if (send && used[i] && up_credit[i] > 0 && coin()) begin
                in_valid[i] = 1'b1;
                up_credit[i]--;
            end
        end
    endtask

    task automatic run_cycles(input int n, input bit send);
        repeat (n) step(send);
    endtask

    // Chunks go out lowest first with random words on every input
    task automatic load_config(input logic [CW-1:0] conf);
        int fv;
        used = '0;
        for (int o = 0; o < NUM_OUT; o++) begin
            fv = int'(conf[SW*o +: SW]);
            if (fv >= 1 && fv <= NUM_IN) used[fv-1] = 1'b1;
        end
        for (int k = 0; k < CW / CHUNK; k++) begin
            step(1'b0);
            conf_en = 1'b1;
            for (int i = 0; i < NUM_IN; i++) begin
                in_valid[i] = coin();
            end
            in_data[NUM_IN-1][CHUNK-1:0] = conf[CHUNK*k +: CHUNK];
        end
        step(1'b0);
        conf_en = 1'b0;
        u_chk.set_config(conf);
    endtask

    task automatic drain();
        int  waited;
        bit  done;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < 400) begin
            step(1'b0);
            waited++;
            done = (u_chk.pending_words() == 0);
            for (int i = 0; i < NUM_IN; i++) begin
                if (up_credit[i] != DEPTH) done = 1'b0;
            end
            for (int o = 0; o < NUM_OUT; o++) begin
                if (owed[o] != 0) done = 1'b0;
            end
        end
        if (!done) begin
            u_chk.report_problem("timed out waiting for queued words and credits to drain");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed        = 59375;
        rst         = 1'b1;
        conf_en     = 1'b0;
        in_data     = '0;
        in_valid    = '0;
        out_credit  = '0;
        used        = '0;
        hold_credit = 1'b0;
        for (int i = 0; i < NUM_IN; i++) up_credit[i] = DEPTH;
        for (int o = 0; o < NUM_OUT; o++) owed[o] = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        u_chk.start_test("reset");
        run_cycles(8, 1'b0);
        u_chk.finish_test();

        // Three distinct inputs with output w left unrouted
        u_chk.start_test("unicast");
        r = rand_below(NUM_IN);
        load_config(pack_conf(r + 1, (r + 1) % NUM_IN + 1, (r + 2) % NUM_IN + 1,
                              (r % 3 == 0) ? 0 : r % 3 + 5));
        run_cycles(80, 1'b1);
        drain();
        u_chk.finish_test();

        u_chk.start_test("multicast");
        r = rand_below(NUM_IN) + 1;
        load_config(pack_conf(r, r, rand_below(NUM_IN) + 1, r));
        run_cycles(80, 1'b1);
        drain();
        u_chk.finish_test();

        // Output n always routed so at least one queue fills
        u_chk.start_test("backpressure");
        load_config(pack_conf(rand_below(NUM_IN) + 1, rand_below(8),
                              rand_below(8), rand_below(8)));
        hold_credit = 1'b1;
        run_cycles(40, 1'b1);
        run_cycles(10, 1'b0);
        hold_credit = 1'b0;
        drain();
        u_chk.finish_test();

        u_chk.start_test("config_mode");
        load_config(pack_conf(rand_below(8), rand_below(8), rand_below(8), rand_below(8)));
        run_cycles(10, 1'b0);
        drain();
        u_chk.finish_test();

        u_chk.start_test("reconfig");
        repeat (2) begin
            load_config(pack_conf(rand_below(NUM_IN) + 1, rand_below(8),
                                  rand_below(NUM_IN) + 1, rand_below(8)));
            run_cycles(60, 1'b1);
            drain();
        end
        u_chk.finish_test();

        $display("summary: %0d run, %0d passed, %0d failing", u_chk.tests_run,
                 u_chk.tests_run - u_chk.tests_failed, u_chk.tests_failed);
        if (u_chk.tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tests/switch_checker.sv
// Reference model and checks for the routing switch
// Expected word queues per output, credit accounting, test reports

`timescale 1ns/10ps
`include "dyser_switch_settings.svh"

module switch_checker (
    input logic                                      clk,
    input logic                                      rst,
    input logic                                      conf_en,
    input logic [`SW_NUM_IN-1:0][`SW_DATA_WIDTH-1:0]  in_data,
    input logic [`SW_NUM_IN-1:0]                     in_valid,
    input logic [`SW_NUM_IN-1:0]                     in_credit,
    input logic [`SW_NUM_OUT-1:0][`SW_DATA_WIDTH-1:0] out_data,
    input logic [`SW_NUM_OUT-1:0]                    out_valid,
    input logic [`SW_NUM_OUT-1:0]                    out_credit
);

    localparam int NUM_IN  = `SW_NUM_IN;
    localparam int NUM_OUT = `SW_NUM_OUT;
    localparam int DW      = `SW_DATA_WIDTH;
    localparam int CW      = `SW_CONF_WIDTH;
    localparam int SW      = `SW_SEL_WIDTH;
    localparam int DEPTH   = `SW_QUEUE_DEPTH;

    logic [CW-1:0] conf_q = '0;
    logic [DW-1:0] exp_q [NUM_OUT][$];
    int            sent [NUM_IN];
    int            returned [NUM_IN];
    int            in_flight [NUM_OUT];
    int            mon_errors = 0;
    int            mon_base = 0;
    int            errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    string         test_name = "none";

    // Input index for an output's field or -1 when it names no input
    function automatic int source_of(input int o);
        int fv;
        fv = int'(conf_q[SW*o +: SW]);
        if (fv >= 1 && fv <= NUM_IN) return fv - 1;
        return -1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Monitor sampled mid cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [DW-1:0] expected;
        if (rst) begin
            for (int o = 0; o < NUM_OUT; o++) begin
                exp_q[o].delete();
                in_flight[o] = 0;
            end
            for (int i = 0; i < NUM_IN; i++) begin
                sent[i]     = 0;
                returned[i] = 0;
            end
        end else begin
            for (int o = 0; o < NUM_OUT; o++) begin
                if (out_valid[o]) begin
                    if (exp_q[o].size() == 0) begin
                        $display("Test %s: output %0d sent %h when no word was due",
                                 test_name, o, out_data[o]);
                        mon_errors++;
                    end else begin
                        expected = exp_q[o].pop_front();
                        if (expected !== out_data[o]) begin
                            $display("Error %s: output %0d expected %h actual %h",
                                     test_name, o, expected, out_data[o]);
                            mon_errors++;
                        end
                    end
                    in_flight[o]++;
                    if (in_flight[o] > DEPTH) begin
                        $display("Test %s: output %0d sent more words than its credit allows",
                                 test_name, o);
                        mon_errors++;
                    end
                end
                if (out_credit[o]) in_flight[o]--;
            end
            // A pulse now can only return a word sent in an earlier cycle
            for (int i = 0; i < NUM_IN; i++) begin
                if (in_credit[i]) begin
                    returned[i]++;
                    if (returned[i] > sent[i]) begin
                        $display("Test %s: input %0d got a credit with no word outstanding",
                                 test_name, i);
                        mon_errors++;
                    end
                end
            end
            // Words offered during configuration are not routed
            if (!conf_en) begin
                for (int i = 0; i < NUM_IN; i++) begin
                    if (in_valid[i]) begin
                        sent[i]++;
                        for (int o = 0; o < NUM_OUT; o++) begin
                            if (source_of(o) == i) exp_q[o].push_back(in_data[i]);
                        end
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test bookkeeping
    //////////////////////////////////////////////////////////////////////

    // Fields the testbench loaded with output n in the low bits
    task automatic set_config(input logic [CW-1:0] conf);
        conf_q = conf;
    endtask

    function automatic int pending_words();
        int total;
        total = 0;
        for (int o = 0; o < NUM_OUT; o++) total += exp_q[o].size();
        return total;
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        errors    = 0;
        mon_base  = mon_errors;
    endtask

    task automatic report_problem(input string what);
        $display("Test %s: %s", test_name, what);
        errors++;
    endtask

    // Credits returned must match words accepted once traffic is idle
    task automatic finish_test();
        int total;
        for (int i = 0; i < NUM_IN; i++) begin
            if (returned[i] != sent[i]) begin
                $display("Error %s: input %0d credit pulses expected %0d actual %0d",
                         test_name, i, sent[i], returned[i]);
                errors++;
            end
        end
        total = errors + mon_errors - mon_base;
        tests_run++;
        if (total == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, total);
            tests_failed++;
        end
    endtask

endmodule

//--- verilog/dyser_switch.sv
// Top level of the credit flow routing switch
// Maps the link ports onto the internal buses and connects the
// configuration register, four output ports and the credit merge

`timescale 1ns/10ps
`include "dyser_switch_settings.svh"

module dyser_switch (
    input  logic              clk,
    input  logic              rst,
    input  logic              conf_en,

    input  switch_pkg::data_t in_nw_data,
    input  switch_pkg::data_t in_n_data,
    input  switch_pkg::data_t in_e_data,
    input  switch_pkg::data_t in_s_data,
    input  switch_pkg::data_t in_w_data,
    input  logic              in_nw_valid,
    input  logic              in_n_valid,
    input  logic              in_e_valid,
    input  logic              in_s_valid,
    input  logic              in_w_valid,
    output logic              in_nw_credit,
    output logic              in_n_credit,
    output logic              in_e_credit,
    output logic              in_s_credit,
    output logic              in_w_credit,

    output switch_pkg::data_t out_n_data,
    output switch_pkg::data_t out_e_data,
    output switch_pkg::data_t out_s_data,
    output switch_pkg::data_t out_w_data,
    output logic              out_n_valid,
    output logic              out_e_valid,
    output logic              out_s_valid,
    output logic              out_w_valid,
    input  logic              out_n_credit,
    input  logic              out_e_credit,
    input  logic              out_s_credit,
    input  logic              out_w_credit
);

    switch_pkg::data_t             out_data_w [`SW_NUM_OUT];
    logic [`SW_NUM_OUT-1:0]        out_valid_w;
    logic [`SW_NUM_OUT-1:0]        out_credit_w;
    logic [`SW_NUM_IN-1:0]         in_credit_w;

    in_bus_if u_in_bus ();
    grant_if  u_grant ();

    // Inputs in bus order nw n e s w
    assign u_in_bus.data  = {in_w_data, in_s_data, in_e_data, in_n_data, in_nw_data};
    assign u_in_bus.valid = {in_w_valid, in_s_valid, in_e_valid, in_n_valid, in_nw_valid};

    switch_config u_config (
        .clk     (clk),
        .rst     (rst),
        .conf_en (conf_en),
        .w_data  (in_w_data),
        .grant   (u_grant)
    );

    ////////////////////////////////////////////////////////////////////////
    // Outputs n e s w
    ////////////////////////////////////////////////////////////////////////

    assign out_credit_w = {out_w_credit, out_s_credit, out_e_credit, out_n_credit};

    for (genvar o = 0; o < `SW_NUM_OUT; o++) begin : g_out
        output_port #(
            .out_index (o)
        ) u_port (
            .clk        (clk),
            .rst        (rst),
            .conf_en    (conf_en),
            .in_bus     (u_in_bus),
            .grant      (u_grant),
            .out_data   (out_data_w[o]),
            .out_valid  (out_valid_w[o]),
            .out_credit (out_credit_w[o])
        );
    end

    assign out_n_data  = out_data_w[0];
    assign out_e_data  = out_data_w[1];
    assign out_s_data  = out_data_w[2];
    assign out_w_data  = out_data_w[3];
    assign {out_w_valid, out_s_valid, out_e_valid, out_n_valid} = out_valid_w;

    credit_merge u_merge (
        .clk       (clk),
        .rst       (rst),
        .grant     (u_grant),
        .in_credit (in_credit_w)
    );

    assign {in_w_credit, in_s_credit, in_e_credit, in_n_credit, in_nw_credit} = in_credit_w;

endmodule

//--- switch/credit_merge.sv
// Upstream credit return of the routing switch
// Holds freed pulses per input and output until every output that
// selects the input has freed a slot

`timescale 1ns/10ps
`include "dyser_switch_settings.svh"

module credit_merge (
    input  logic                  clk,
    input  logic                  rst,
    grant_if.merge_side           grant,
    output logic [`SW_NUM_IN-1:0] in_credit
);

    localparam int NUM_IN  = `SW_NUM_IN;
    localparam int NUM_OUT = `SW_NUM_OUT;
    // A multicast output may run ahead by up to a full queue
    localparam int CNT_W   = $clog2(`SW_QUEUE_DEPTH + 1);

    logic [NUM_IN-1:0][NUM_OUT-1:0] sel;
    logic [NUM_IN-1:0][NUM_OUT-1:0] ready;
    logic [CNT_W-1:0]               saved [NUM_IN][NUM_OUT];

    //////////////////////////////////////////////////////////////////////
    // Per input and output hold counters
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_IN; i++) begin : g_in
        for (genvar o = 0; o < NUM_OUT; o++) begin : g_out
            assign sel[i][o] = (grant.src_field[o] == switch_pkg::src_sel_e'(i + 1));

            // Freed now or freed earlier and not yet passed upstream
            assign ready[i][o] = (saved[i][o] != '0) | grant.freed[o];

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    saved[i][o] <= '0;
                end else begin
                    saved[i][o] <= saved[i][o]
                                 + CNT_W'(sel[i][o] & grant.freed[o])
                                 - CNT_W'(sel[i][o] & in_credit[i]);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Merge
    //////////////////////////////////////////////////////////////////////

    // AND over the selecting outputs, no pulse for an unused input
    always_comb begin
        for (int i = 0; i < NUM_IN; i++) begin
            in_credit[i] = |sel[i];
            for (int o = 0; o < NUM_OUT; o++) begin
                if (sel[i][o] && !ready[i][o]) begin
                    in_credit[i] = 1'b0;
                end
            end
        end
    end

endmodule

//--- switch/output_port.sv
// One output link of the routing switch
// Source mux, two entry queue, registered output stage and the
// downstream credit counter

`timescale 1ns/10ps
`include "dyser_switch_settings.svh"

module output_port #(
    parameter int out_index = 0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              conf_en,
    in_bus_if.dst             in_bus,
    grant_if.port_side        grant,
    output switch_pkg::data_t out_data,
    output logic              out_valid,
    input  logic              out_credit
);

    localparam int DEPTH = `SW_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    switch_pkg::data_t sel_data;
    logic              sel_valid;
    logic              push;
    logic              pop;

    switch_pkg::data_t queue_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fill;
    logic [CNT_W-1:0]  credit;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Source select
    //////////////////////////////////////////////////////////////////////

    // Field value k picks input k-1, none and 6/7 pick nothing
    always_comb begin
        sel_data  = in_bus.data[0];
        sel_valid = 1'b0;
        for (int i = 0; i < `SW_NUM_IN; i++) begin
            if (grant.src_field[out_index] == switch_pkg::src_sel_e'(i + 1)) begin
                sel_data  = in_bus.data[i];
                sel_valid = in_bus.valid[i];
            end
        end
    end

    // Words seen during configuration are dropped
    assign push = sel_valid & ~conf_en;
    assign pop  = (fill != '0) && (credit != '0);

    // Slot freed in the same cycle as the pop
    assign grant.freed[out_index] = pop;

    //////////////////////////////////////////////////////////////////////
    // Queue
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= sel_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            fill <= fill + CNT_W'(push) - CNT_W'(pop);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output stage and downstream credit
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pop) begin
            out_data <= queue_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            credit    <= CNT_W'(DEPTH);
        end else begin
            out_valid <= pop;
            // One down per word sent, one up per returned pulse
            credit    <= credit - CNT_W'(pop) + CNT_W'(out_credit);
        end
    end

endmodule

//--- switch/switch_config.sv
// Configuration register of the routing switch
// Loaded in chunks from w data while conf_en is high

`timescale 1ns/10ps
`include "dyser_switch_settings.svh"

module switch_config (
    input  logic              clk,
    input  logic              rst,
    input  logic              conf_en,
    input  switch_pkg::data_t w_data,
    grant_if.conf_side        grant
);

    localparam int CONF_W  = `SW_CONF_WIDTH;
    localparam int CHUNK_W = `SW_CONF_CHUNK;

    switch_pkg::conf_u conf_q;
    logic [CHUNK_W-1:0] chunk;

    // Low bits of the west word carry the configuration
    assign chunk = w_data[CHUNK_W-1:0];

    // New chunk enters at the top, older chunks move toward bit 0
    // so the first chunk loaded ends up in the lowest field
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            conf_q.conf_bits <= '0;
        end else if (conf_en) begin
            conf_q.conf_bits <= {chunk, conf_q.conf_bits[CONF_W-1:CHUNK_W]};
        end
    end

    // Routing view of the same word
    assign grant.src_field = conf_q.conf_fields;

endmodule

//--- common/switch_if.sv
// Internal buses of the routing switch
// in_bus_if carries the five input words, grant_if the per output
// source fields and freed slot pulses

`timescale 1ns/10ps
`include "dyser_switch_settings.svh"

////////////////////////////////////////////////////////////////////////
// Input word bus
////////////////////////////////////////////////////////////////////////

// Index 0 nw, 1 n, 2 e, 3 s, 4 w
interface in_bus_if;

    switch_pkg::data_t [`SW_NUM_IN-1:0] data;
    logic [`SW_NUM_IN-1:0]              valid;

    modport src (
        output data,
        output valid
    );

    modport dst (
        input data,
        input valid
    );

endinterface

////////////////////////////////////////////////////////////////////////
// Source fields and credit return
////////////////////////////////////////////////////////////////////////

// Index 0 n, 1 e, 2 s, 3 w
interface grant_if;

    switch_pkg::src_sel_e [`SW_NUM_OUT-1:0] src_field;
    // One cycle high when the output queue pops
    logic [`SW_NUM_OUT-1:0]                 freed;

    modport port_side (
        input  src_field,
        output freed
    );

    modport merge_side (
        input src_field,
        input freed
    );

    modport conf_side (
        output src_field
    );

endinterface

//--- common/switch_pkg.sv
// Shared types for the routing switch
// Data word, source select encoding and the configuration union

`include "dyser_switch_settings.svh"

package switch_pkg;

    // One link's data word
    typedef logic [`SW_DATA_WIDTH-1:0] data_t;

    // Source select per output
    // Codes 6 and 7 match no input and behave as none
    typedef enum logic [`SW_SEL_WIDTH-1:0] {
        src_none = 3'd0,
        src_nw   = 3'd1,
        src_n    = 3'd2,
        src_e    = 3'd3,
        src_s    = 3'd4,
        src_w    = 3'd5
    } src_sel_e;

    ////////////////////////////////////////////////////////////////////
    // Configuration word
    ////////////////////////////////////////////////////////////////////

    // Flat bits while shifting in, per output fields while routing
    // Field 0 is output n and sits in the low bits, then e, s, w
    typedef union packed {
        logic [`SW_CONF_WIDTH-1:0]        conf_bits;
        src_sel_e [`SW_NUM_OUT-1:0]       conf_fields;
    } conf_u;

endpackage

//--- common/dyser_switch_settings.svh
// Sizing macros for the routing switch
// Link width, port counts, configuration layout and queue depth

`ifndef DYSER_SWITCH_SETTINGS_SVH
`define DYSER_SWITCH_SETTINGS_SVH

// Link payload
`define SW_DATA_WIDTH   16

// Port counts, inputs nw n e s w and outputs n e s w
`define SW_NUM_IN       5
`define SW_NUM_OUT      4

// One source field per output
`define SW_SEL_WIDTH    3

// Whole configuration word and the slice taken from w data per load cycle
`define SW_CONF_WIDTH   12
`define SW_CONF_CHUNK   4

// Output queue entries, also the starting credit on every link
`define SW_QUEUE_DEPTH  2

`endif
